/* common/soc_pkg.sv */
// SoC bus fabric definitions
package soc_pkg;

    // Wishbone bus widths, word addressed
    localparam int BUS_AW = 28;
    localparam int BUS_DW = 32;
    localparam int BUS_SW = 4;

    typedef logic [BUS_AW-1:0] wb_adr_t;   // Word address
    typedef logic [BUS_DW-1:0] wb_dat_t;
    typedef logic [BUS_SW-1:0] wb_sel_t;

    // Address map, byte values shifted down to word addresses
    localparam wb_adr_t DMEM_BASE   = wb_adr_t'(32'h0002_0000 >> 2);
    localparam wb_adr_t DMEM_MASK   = wb_adr_t'(~(32'h0000_0fff >> 2));   // 4 KiB
    localparam wb_adr_t SHARED_BASE = wb_adr_t'(32'h1000_0000 >> 2);
    localparam wb_adr_t SHARED_MASK = wb_adr_t'(~(32'h000f_ffff >> 2));   // 1 MiB

    // GPIO windows on the shared bus, 16 bytes each
    localparam wb_adr_t GPIO0_BASE = wb_adr_t'(32'h1000_0000 >> 2);
    localparam wb_adr_t GPIO1_BASE = wb_adr_t'(32'h1000_0010 >> 2);
    localparam wb_adr_t GPIO_MASK  = wb_adr_t'(~(32'h0000_000f >> 2));

    // Memory word address width follows the window size
    localparam int DMEM_AW = $countones(~DMEM_MASK);

    // First-level decode result
    typedef enum logic [1:0] {
        TGT_DMEM,
        TGT_SHARED,
        TGT_NONE
    } xbar_tgt_e;

    // Word offsets inside a GPIO window
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_DIR = 2'd1,
        GPIO_IN  = 2'd2
    } gpio_reg_e;

    localparam int GPIO0_WIDTH = 8;
    localparam int GPIO1_WIDTH = 4;

    // Outstanding request counter in the decoder
    localparam int OUTST_W = 3;

endpackage

/* logic/gpio_port.sv */
// GPIO port registers
`timescale 1ns/1ps

module gpio_port #(
    parameter int WIDTH = 8
) (
    input  logic               sys_clk,
    input  logic               rst_i,
    input  logic               wr_i,
    input  soc_pkg::gpio_reg_e rd_sel_i,
    input  logic [WIDTH-1:0]   wdat_i,
    input  logic               byte_en_i,
    output soc_pkg::wb_dat_t   rdat_o,
    input  logic [WIDTH-1:0]   pin_i,
    output logic [WIDTH-1:0]   pin_out_o,
    output logic [WIDTH-1:0]   pin_oe_o
);
    import soc_pkg::*;

    logic [WIDTH-1:0] out_q;
    logic [WIDTH-1:0] dir_q;    // 1 drives the pin
    logic [WIDTH-1:0] sync_q;
    logic [WIDTH-1:0] in_q;

    always_ff @(posedge sys_clk)
    begin
        if (rst_i)
        begin
            out_q <= '0;
            dir_q <= '0;
        end
        else if (wr_i && byte_en_i)
        begin
            if (rd_sel_i == GPIO_OUT)
                out_q <= wdat_i;
            else if (rd_sel_i == GPIO_DIR)
                dir_q <= wdat_i;
        end
    end

    // Two flops from the pins to the input register
    always_ff @(posedge sys_clk)
    begin
        sync_q <= pin_i;
        in_q   <= sync_q;
    end

    assign pin_out_o = out_q;
    assign pin_oe_o  = dir_q;

    always_comb
    begin
        rdat_o = '0;
        case (rd_sel_i)
            GPIO_OUT: rdat_o[WIDTH-1:0] = out_q;
            GPIO_DIR: rdat_o[WIDTH-1:0] = dir_q;
            GPIO_IN:  rdat_o[WIDTH-1:0] = in_q;
            default:  rdat_o = '0;   // Unused offset
        endcase
    end

endmodule

/* logic/dmem_ram.sv */
// Data memory with Wishbone slave port
`timescale 1ns/1ps

module dmem_ram (
    input  logic                         sys_clk,
    input  logic                         rst_i,
    input  logic                         stb_i,
    input  logic                         we_i,
    input  logic [soc_pkg::DMEM_AW-1:0]  adr_i,
    input  soc_pkg::wb_dat_t             dat_i,
    input  soc_pkg::wb_sel_t             sel_i,
    output logic                         stall_o,
    output logic                         ack_o,
    output soc_pkg::wb_dat_t             dat_o
);
    import soc_pkg::*;

    wb_dat_t mem [2**DMEM_AW];

    // Single cycle access, a new request every clock
    assign stall_o = 1'b0;

    // Byte lane writes
    always_ff @(posedge sys_clk)
    begin
        if (stb_i && we_i)
        begin
            for (int i = 0; i < BUS_SW; i++)
            begin
                if (sel_i[i])
                    mem[adr_i][8*i +: 8] <= dat_i[8*i +: 8];
            end
        end
    end

    // Registered read, old contents on a write
    always_ff @(posedge sys_clk)
    begin
        if (stb_i)
            dat_o <= mem[adr_i];
    end

    always_ff @(posedge sys_clk)
    begin
        if (rst_i)
            ack_o <= 1'b0;
        else
            ack_o <= stb_i;   // One cycle after the strobe
    end

endmodule

/* bus/shared_bus.sv */
// Registered shared peripheral bus
`timescale 1ns/1ps

module shared_bus (
    input  logic                              sys_clk,
    input  logic                              rst_i,
    input  logic                              stb_i,
    input  logic                              we_i,
    input  soc_pkg::wb_adr_t                  adr_i,
    input  soc_pkg::wb_dat_t                  dat_i,
    input  soc_pkg::wb_sel_t                  sel_i,
    output logic                              stall_o,
    output logic                              ack_o,
    output logic                              err_o,
    output soc_pkg::wb_dat_t                  dat_o,
    input  logic [soc_pkg::GPIO0_WIDTH-1:0]   gpio0_in_i,
    input  logic [soc_pkg::GPIO1_WIDTH-1:0]   gpio1_in_i,
    output logic [soc_pkg::GPIO0_WIDTH-1:0]   gpio0_out_o,
    output logic [soc_pkg::GPIO0_WIDTH-1:0]   gpio0_oe_o,
    output logic [soc_pkg::GPIO1_WIDTH-1:0]   gpio1_out_o,
    output logic [soc_pkg::GPIO1_WIDTH-1:0]   gpio1_oe_o
);
    import soc_pkg::*;

    gpio_reg_e reg_sel;
    logic      accept;
    logic      hit0;
    logic      hit1;
    logic      reg_ok;
    logic      req_q;       // One request held
    logic      mapped_q;
    wb_dat_t   rdat0;
    wb_dat_t   rdat1;

    assign accept  = stb_i & ~req_q;
    assign stall_o = req_q;

    assign reg_sel = gpio_reg_e'(adr_i[1:0]);
    assign hit0    = (adr_i & GPIO_MASK) == GPIO0_BASE;
    assign hit1    = (adr_i & GPIO_MASK) == GPIO1_BASE;
    assign reg_ok  = (reg_sel == GPIO_OUT) || (reg_sel == GPIO_DIR) || (reg_sel == GPIO_IN);

    gpio_port #(.WIDTH(GPIO0_WIDTH)) gpio0_inst (
        .sys_clk   (sys_clk),
        .rst_i     (rst_i),
        .wr_i      (accept & we_i & hit0),
        .rd_sel_i  (reg_sel),
        .wdat_i    (dat_i[GPIO0_WIDTH-1:0]),
        .byte_en_i (sel_i[0]),
        .rdat_o    (rdat0),
        .pin_i     (gpio0_in_i),
        .pin_out_o (gpio0_out_o),
        .pin_oe_o  (gpio0_oe_o)
    );

    gpio_port #(.WIDTH(GPIO1_WIDTH)) gpio1_inst (
        .sys_clk   (sys_clk),
        .rst_i     (rst_i),
        .wr_i      (accept & we_i & hit1),
        .rd_sel_i  (reg_sel),
        .wdat_i    (dat_i[GPIO1_WIDTH-1:0]),
        .byte_en_i (sel_i[0]),
        .rdat_o    (rdat1),
        .pin_i     (gpio1_in_i),
        .pin_out_o (gpio1_out_o),
        .pin_oe_o  (gpio1_oe_o)
    );

    always_ff @(posedge sys_clk)
    begin
        if (rst_i)
        begin
            req_q    <= 1'b0;
            mapped_q <= 1'b0;
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
        end
        else
        begin
            req_q    <= accept;
            mapped_q <= (hit0 | hit1) & reg_ok;
            ack_o    <= req_q & mapped_q;   // Answer in the cycle after capture
            err_o    <= req_q & ~mapped_q;
        end
    end

    // Read data captured with the request, held through the ack cycle
    always_ff @(posedge sys_clk)
    begin
        if (accept)
            dat_o <= hit1 ? rdat1 : rdat0;
    end

endmodule

/* bus/bus_decoder.sv */
// First-level Wishbone address decoder
`timescale 1ns/1ps

module bus_decoder (
    input  logic             sys_clk,
    input  logic             rst_i,
    // Master port
    input  logic             wbm_cyc_i,
    input  logic             wbm_stb_i,
    input  logic             wbm_we_i,
    input  soc_pkg::wb_adr_t wbm_adr_i,
    input  soc_pkg::wb_dat_t wbm_dat_i,
    input  soc_pkg::wb_sel_t wbm_sel_i,
    output logic             wbm_stall_o,
    output logic             wbm_ack_o,
    output logic             wbm_err_o,
    output soc_pkg::wb_dat_t wbm_dat_o,
    // DMEM target
    output logic             dmem_stb_o,
    output logic             dmem_we_o,
    output soc_pkg::wb_adr_t dmem_adr_o,
    output soc_pkg::wb_dat_t dmem_dat_o,
    output soc_pkg::wb_sel_t dmem_sel_o,
    input  logic             dmem_stall_i,
    input  logic             dmem_ack_i,
    input  logic             dmem_err_i,
    input  soc_pkg::wb_dat_t dmem_dat_i,
    // Shared bus target
    output logic             shr_stb_o,
    output logic             shr_we_o,
    output soc_pkg::wb_adr_t shr_adr_o,
    output soc_pkg::wb_dat_t shr_dat_o,
    output soc_pkg::wb_sel_t shr_sel_o,
    input  logic             shr_stall_i,
    input  logic             shr_ack_i,
    input  logic             shr_err_i,
    input  soc_pkg::wb_dat_t shr_dat_i
);
    import soc_pkg::*;

    xbar_tgt_e          req_tgt;
    xbar_tgt_e          cur_tgt;      // Target of the requests in flight
    logic [OUTST_W-1:0] outst_cnt;
    logic               blocked;
    logic               tgt_stall;
    logic               fwd;
    logic               accept;
    logic               resp;
    logic               none_err_q;   // Error for an unclaimed address

    always_comb
    begin
        if ((wbm_adr_i & DMEM_MASK) == DMEM_BASE)
            req_tgt = TGT_DMEM;
        else if ((wbm_adr_i & SHARED_MASK) == SHARED_BASE)
            req_tgt = TGT_SHARED;
        else
            req_tgt = TGT_NONE;
    end

    // Hold off a switch of target until the pipe has drained
    assign blocked = ((outst_cnt != '0) && (req_tgt != cur_tgt)) || (outst_cnt == '1);

    always_comb
    begin
        case (req_tgt)
            TGT_DMEM:   tgt_stall = dmem_stall_i;
            TGT_SHARED: tgt_stall = shr_stall_i;
            default:    tgt_stall = 1'b0;
        endcase
    end

    assign wbm_stall_o = wbm_cyc_i & wbm_stb_i & (blocked | tgt_stall);
    assign fwd         = wbm_cyc_i & wbm_stb_i & ~blocked;
    assign accept      = wbm_cyc_i & wbm_stb_i & ~wbm_stall_o;

    assign dmem_stb_o = fwd & (req_tgt == TGT_DMEM);
    assign dmem_we_o  = wbm_we_i;
    assign dmem_adr_o = wbm_adr_i;
    assign dmem_dat_o = wbm_dat_i;
    assign dmem_sel_o = wbm_sel_i;

    assign shr_stb_o = fwd & (req_tgt == TGT_SHARED);
    assign shr_we_o  = wbm_we_i;
    assign shr_adr_o = wbm_adr_i;
    assign shr_dat_o = wbm_dat_i;
    assign shr_sel_o = wbm_sel_i;

    // Responses come only from the target in flight
    always_comb
    begin
        case (cur_tgt)
            TGT_DMEM:
            begin
                wbm_ack_o = dmem_ack_i;
                wbm_err_o = dmem_err_i;
                wbm_dat_o = dmem_dat_i;
            end
            TGT_SHARED:
            begin
                wbm_ack_o = shr_ack_i;
                wbm_err_o = shr_err_i;
                wbm_dat_o = shr_dat_i;
            end
            default:
            begin
                wbm_ack_o = 1'b0;
                wbm_err_o = none_err_q;
                wbm_dat_o = '0;
            end
        endcase
    end

    assign resp = wbm_ack_o | wbm_err_o;

    always_ff @(posedge sys_clk)
    begin
        if (rst_i)
        begin
            outst_cnt  <= '0;
            cur_tgt    <= TGT_NONE;
            none_err_q <= 1'b0;
        end
        else
        begin
            none_err_q <= accept && (req_tgt == TGT_NONE);
            if (accept)
                cur_tgt <= req_tgt;
            case ({accept, resp})
                2'b10:   outst_cnt <= outst_cnt + 1'b1;
                2'b01:   outst_cnt <= outst_cnt - 1'b1;
                default: outst_cnt <= outst_cnt;   // Both or neither
            endcase
        end
    end

endmodule

/* logic/soc_top.sv */
// SoC bus fabric top level
`timescale 1ns/1ps

module soc_top (
    input  logic                             sys_clk,
    input  logic                             rst_i,
    input  logic                             wbm_cyc_i,
    input  logic                             wbm_stb_i,
    input  logic                             wbm_we_i,
    input  soc_pkg::wb_adr_t                 wbm_adr_i,
    input  soc_pkg::wb_dat_t                 wbm_dat_i,
    input  soc_pkg::wb_sel_t                 wbm_sel_i,
    output logic                             wbm_stall_o,
    output logic                             wbm_ack_o,
    output logic                             wbm_err_o,
    output soc_pkg::wb_dat_t                 wbm_dat_o,
    input  logic [soc_pkg::GPIO0_WIDTH-1:0]  gpio0_in_i,
    input  logic [soc_pkg::GPIO1_WIDTH-1:0]  gpio1_in_i,
    output logic [soc_pkg::GPIO0_WIDTH-1:0]  gpio0_out_o,
    output logic [soc_pkg::GPIO0_WIDTH-1:0]  gpio0_oe_o,
    output logic [soc_pkg::GPIO1_WIDTH-1:0]  gpio1_out_o,
    output logic [soc_pkg::GPIO1_WIDTH-1:0]  gpio1_oe_o
);
    import soc_pkg::*;

    // Decoder to DMEM
    logic    dmem_stb, dmem_we, dmem_stall, dmem_ack;
    wb_adr_t dmem_adr;
    wb_dat_t dmem_dat_w, dmem_dat_r;
    wb_sel_t dmem_sel;

    // Decoder to shared bus
    logic    shr_stb, shr_we, shr_stall, shr_ack, shr_err;
    wb_adr_t shr_adr;
    wb_dat_t shr_dat_w, shr_dat_r;
    wb_sel_t shr_sel;

    bus_decoder bus_decoder_inst (
        .sys_clk(sys_clk), .rst_i(rst_i),
        .wbm_cyc_i(wbm_cyc_i), .wbm_stb_i(wbm_stb_i), .wbm_we_i(wbm_we_i),
        .wbm_adr_i(wbm_adr_i), .wbm_dat_i(wbm_dat_i), .wbm_sel_i(wbm_sel_i),
        .wbm_stall_o(wbm_stall_o), .wbm_ack_o(wbm_ack_o), .wbm_err_o(wbm_err_o),
        .wbm_dat_o(wbm_dat_o),
        .dmem_stb_o(dmem_stb), .dmem_we_o(dmem_we), .dmem_adr_o(dmem_adr),
        .dmem_dat_o(dmem_dat_w), .dmem_sel_o(dmem_sel),
        .dmem_stall_i(dmem_stall), .dmem_ack_i(dmem_ack),
        .dmem_err_i(1'b0),   // Memory never errors
        .dmem_dat_i(dmem_dat_r),
        .shr_stb_o(shr_stb), .shr_we_o(shr_we), .shr_adr_o(shr_adr),
        .shr_dat_o(shr_dat_w), .shr_sel_o(shr_sel),
        .shr_stall_i(shr_stall), .shr_ack_i(shr_ack), .shr_err_i(shr_err),
        .shr_dat_i(shr_dat_r)
    );

    dmem_ram dmem_inst (
        .sys_clk(sys_clk), .rst_i(rst_i),
        .stb_i(dmem_stb), .we_i(dmem_we),
        .adr_i(dmem_adr[DMEM_AW-1:0]),   // Offset within the window
        .dat_i(dmem_dat_w), .sel_i(dmem_sel),
        .stall_o(dmem_stall), .ack_o(dmem_ack), .dat_o(dmem_dat_r)
    );

    shared_bus shared_bus_inst (
        .sys_clk(sys_clk), .rst_i(rst_i),
        .stb_i(shr_stb), .we_i(shr_we), .adr_i(shr_adr),
        .dat_i(shr_dat_w), .sel_i(shr_sel),
        .stall_o(shr_stall), .ack_o(shr_ack), .err_o(shr_err), .dat_o(shr_dat_r),
        .gpio0_in_i(gpio0_in_i), .gpio1_in_i(gpio1_in_i),
        .gpio0_out_o(gpio0_out_o), .gpio0_oe_o(gpio0_oe_o),
        .gpio1_out_o(gpio1_out_o), .gpio1_oe_o(gpio1_oe_o)
    );

endmodule

/* tests/soc_asserts.sv */
// Decoder protocol assertions
`timescale 1ns/1ps

module soc_bus_asserts (
    input logic                        sys_clk,
    input logic                        rst_i,
    input logic                        wbm_ack_o,
    input logic                        wbm_err_o,
    input logic                        dmem_stb_o,
    input logic                        shr_stb_o,
    input logic [soc_pkg::OUTST_W-1:0] outst_cnt,
    input soc_pkg::xbar_tgt_e          cur_tgt
);
    import soc_pkg::*;

    // One kind of response per cycle
    ack_err_excl: assert property (@(posedge sys_clk) disable iff (rst_i)
        !(wbm_ack_o && wbm_err_o))
        else $error("ack and err high in the same cycle");

    // A response needs a request in flight
    resp_outstanding: assert property (@(posedge sys_clk) disable iff (rst_i)
        (wbm_ack_o || wbm_err_o) |-> (outst_cnt != '0))
        else $error("response with no outstanding request, target %0d", cur_tgt);

    // Requests in flight all belong to one target
    stb_one_target: assert property (@(posedge sys_clk) disable iff (rst_i)
        ((dmem_stb_o || shr_stb_o) && (outst_cnt != '0)) |->
            (cur_tgt == (dmem_stb_o ? TGT_DMEM : TGT_SHARED)))
        else $error("stb forwarded to a second target while requests are in flight");

endmodule

bind bus_decoder soc_bus_asserts bus_asserts_inst (
    .sys_clk    (sys_clk),
    .rst_i      (rst_i),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .dmem_stb_o (dmem_stb_o),
    .shr_stb_o  (shr_stb_o),
    .outst_cnt  (outst_cnt),
    .cur_tgt    (cur_tgt)
);

/* tests/soc_tb.sv */
// SoC bus fabric testbench
`timescale 1ns/1ps

module soc_tb;
    import soc_pkg::*;

    logic                   sys_clk;
    logic                   rst_i;
    logic                   wbm_cyc_i, wbm_stb_i, wbm_we_i;
    wb_adr_t                wbm_adr_i;
    wb_dat_t                wbm_dat_i;
    wb_sel_t                wbm_sel_i;
    logic                   wbm_stall_o, wbm_ack_o, wbm_err_o;
    wb_dat_t                wbm_dat_o;
    logic [GPIO0_WIDTH-1:0] gpio0_in_i, gpio0_out_o, gpio0_oe_o;
    logic [GPIO1_WIDTH-1:0] gpio1_in_i, gpio1_out_o, gpio1_oe_o;

    // Parsed pattern lines
    string       pat_name[$];
    string       pat_op[$];
    logic [31:0] pat_adr[$], pat_dat[$], pat_sel[$], pat_exp[$];
    int          pat_err[$];
    int          num_patterns = 0;
    int          err_count = 0;

    // Pending requests and collected responses
    logic        req_we[$];
    logic [31:0] req_adr[$], req_dat[$];
    logic [3:0]  req_sel[$];
    logic [31:0] rsp_dat[$];
    logic        rsp_err[$];

    logic [31:0] mem_model[int];   // Keyed by byte address
    logic [31:0] gpio_out_m[2], gpio_dir_m[2];
    logic [15:0] lfsr_q = 16'd46;

    soc_top UUT (.*);

    initial
    begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // Taps 16 14 13 11, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            err_count++;
            fail_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic push_req(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        req_we.push_back(we);
        req_adr.push_back(adr);
        req_dat.push_back(dat);
        req_sel.push_back(sel);
    endtask

    task automatic drive_req(input int i);
        wbm_stb_i <= 1'b1;
        wbm_we_i  <= req_we[i];
        wbm_adr_i <= wb_adr_t'(req_adr[i] >> 2);
        wbm_dat_i <= req_dat[i];
        wbm_sel_i <= req_sel[i];
    endtask

    // Issue all queued requests back to back and gather responses
    task automatic run_requests();
        int   n;
        int   issued;
        int   cycles;
        logic acc;
        n = req_we.size();
        issued = 0;
        cycles = 0;
        rsp_dat.delete();
        rsp_err.delete();
        @(posedge sys_clk);
        wbm_cyc_i <= 1'b1;
        drive_req(0);
        while (rsp_dat.size() < n)
        begin
            @(negedge sys_clk);   // Sample between edges
            acc = wbm_stb_i && !wbm_stall_o;
            if (wbm_ack_o || wbm_err_o)
            begin
                rsp_dat.push_back(wbm_dat_o);
                rsp_err.push_back(wbm_err_o);
            end
            cycles++;
            if (cycles > 20 * n + 10)
                fail_run("Bus responses missing, request sequence timed out");
            @(posedge sys_clk);
            if (acc)
            begin
                issued++;
                if (issued < n)
                    drive_req(issued);
                else
                    wbm_stb_i <= 1'b0;
            end
        end
        assert (issued == n)
        else fail_run("Responses arrived for requests that were never accepted");
        wbm_cyc_i <= 1'b0;
        wbm_stb_i <= 1'b0;
        req_we.delete();
        req_adr.delete();
        req_dat.delete();
        req_sel.delete();
    endtask

    function automatic bit is_dmem(input logic [31:0] a);
        return (a & 32'hffff_f000) == 32'h0002_0000;
    endfunction

    function automatic int gpio_port_of(input logic [31:0] a);
        if ((a & 32'hffff_fff0) == 32'h1000_0000)
            return 0;
        if ((a & 32'hffff_fff0) == 32'h1000_0010)
            return 1;
        return -1;
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] w;
        int          p;
        int          wid;
        p = gpio_port_of(a);
        if (is_dmem(a))
        begin
            w = mem_model.exists(a) ? mem_model[a] : 32'h0;
            for (int i = 0; i < 4; i++)
                if (s[i])
                    w[8*i +: 8] = d[8*i +: 8];
            mem_model[a] = w;
        end
        else if (p >= 0 && s[0])
        begin
            wid = (p == 0) ? GPIO0_WIDTH : GPIO1_WIDTH;
            if (a[3:2] == 2'd0)
                gpio_out_m[p] = d & ((32'h1 << wid) - 1);   // Truncated to port width
            else if (a[3:2] == 2'd1)
                gpio_dir_m[p] = d & ((32'h1 << wid) - 1);
        end
    endtask

    task automatic check_pins(input string name);
        check_value({name, "_out0"}, gpio_out_m[0], 32'(gpio0_out_o));
        check_value({name, "_oe0"}, gpio_dir_m[0], 32'(gpio0_oe_o));
        check_value({name, "_out1"}, gpio_out_m[1], 32'(gpio1_out_o));
        check_value({name, "_oe1"}, gpio_dir_m[1], 32'(gpio1_oe_o));
    endtask

    task automatic run_pattern(input int k);
        logic [31:0] v;
        logic [31:0] bdat[8];
        int          tries;
        int          acks;
        case (pat_op[k])
            "wr":
            begin
                push_req(1'b1, pat_adr[k], pat_dat[k], pat_sel[k][3:0]);
                run_requests();
                check_value({pat_name[k], "_err"}, 32'(pat_err[k]), 32'(rsp_err[0]));
                if (pat_err[k] == 0)
                    model_write(pat_adr[k], pat_dat[k], pat_sel[k][3:0]);
                check_pins(pat_name[k]);
            end
            "rd":
            begin
                push_req(1'b0, pat_adr[k], 32'h0, pat_sel[k][3:0]);
                run_requests();
                check_value({pat_name[k], "_err"}, 32'(pat_err[k]), 32'(rsp_err[0]));
                if (pat_err[k] == 0)
                begin
                    check_value(pat_name[k], pat_exp[k], rsp_dat[0]);
                    if (is_dmem(pat_adr[k]))
                        check_value({pat_name[k], "_model"}, mem_model[pat_adr[k]], pat_exp[k]);
                end
            end
            "burst":
            begin
                for (int i = 0; i < 8; i++)
                begin
                    bdat[i] = lfsr_bits(32);
                    push_req(1'b1, pat_adr[k] + 4 * i, bdat[i], 4'hf);
                end
                for (int i = 0; i < 8; i++)
                    push_req(1'b0, pat_adr[k] + 4 * i, 32'h0, 4'hf);
                run_requests();
                acks = 0;
                for (int i = 0; i < 16; i++)
                begin
                    if (rsp_err[i] === 1'b0)
                        acks++;   // Writes and reads alike
                end
                check_value({pat_name[k], "_count"}, 32'd16, 32'(acks));
                for (int i = 0; i < 8; i++)
                begin
                    model_write(pat_adr[k] + 4 * i, bdat[i], 4'hf);
                    check_value($sformatf("%s_rd%0d", pat_name[k], i), bdat[i], rsp_dat[8 + i]);
                end
            end
            "pin":
            begin
                @(posedge sys_clk);
                if (gpio_port_of(pat_adr[k]) == 0)
                begin
                    v = lfsr_bits(GPIO0_WIDTH);
                    gpio0_in_i <= v[GPIO0_WIDTH-1:0];
                end
                else
                begin
                    v = lfsr_bits(GPIO1_WIDTH);
                    gpio1_in_i <= v[GPIO1_WIDTH-1:0];
                end
                tries = 0;
                do
                begin
                    push_req(1'b0, pat_adr[k], 32'h0, 4'hf);
                    run_requests();
                    tries++;
                end
                while (rsp_dat[0] !== v && tries < 8);
                check_value(pat_name[k], v, rsp_dat[0]);
            end
            default: fail_run($sformatf("Unknown operation %s in pattern file", pat_op[k]));
        endcase
    endtask

    task automatic load_patterns();
        int          fd;
        int          cnt;
        string       line, nm, op;
        logic [31:0] a, d, s, e;
        int          ef;
        fd = $fopen("tests/soc_patterns.txt", "r");
        if (fd == 0)
            fail_run("Cannot open the pattern file");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue;   // Blank or comment
            cnt = $sscanf(line, "%s %s %h %h %h %h %d", nm, op, a, d, s, e, ef);
            if (cnt != 7)
                fail_run($sformatf("Malformed pattern line: %s", line));
            pat_name.push_back(nm);
            pat_op.push_back(op);
            pat_adr.push_back(a);
            pat_dat.push_back(d);
            pat_sel.push_back(s);
            pat_exp.push_back(e);
            pat_err.push_back(ef);
        end
        $fclose(fd);
        num_patterns = pat_name.size();
        if (num_patterns == 0)
            fail_run("The pattern file holds no transactions");
    endtask

    initial
    begin
        rst_i      = 1'b1;
        wbm_cyc_i  = 1'b0;
        wbm_stb_i  = 1'b0;
        wbm_we_i   = 1'b0;
        wbm_adr_i  = '0;
        wbm_dat_i  = '0;
        wbm_sel_i  = '0;
        gpio0_in_i = '0;
        gpio1_in_i = '0;
        gpio_out_m = '{32'h0, 32'h0};
        gpio_dir_m = '{32'h0, 32'h0};
        load_patterns();
        repeat (8) @(posedge sys_clk);
        rst_i <= 1'b0;
        @(negedge sys_clk);
        check_value("reset_ack", 32'h0, 32'(wbm_ack_o));
        check_value("reset_err", 32'h0, 32'(wbm_err_o));
        check_value("reset_stall", 32'h0, 32'(wbm_stall_o));
        check_pins("reset");
        for (int k = 0; k < num_patterns; k++)
            run_pattern(k);
        repeat (2) @(posedge sys_clk);
        if (err_count == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("Regression failed");
            $fatal(1);
        end
    end

    // Run limit from pattern count plus reset
    initial
    begin
        wait (num_patterns > 0);
        repeat (num_patterns * 20 + 8) @(posedge sys_clk);
        $display("Watchdog expired before the patterns completed");
        $display("Regression failed");
        $fatal(1);
    end

endmodule

/* tests/soc_patterns.txt */
# name op byte_addr data sel expected err
# ops wr rd burst pin, hex fields, err is 1 when an error response is expected
dm_full0   wr    00020000 11223344 f 00000000 0
dm_lane0   wr    00020000 000000aa 1 00000000 0
dm_hi0     wr    00020000 bbcc0000 c 00000000 0
dm_rd0     rd    00020000 00000000 f bbcc33aa 0
dm_full1   wr    00020004 cafef00d f 00000000 0
dm_lane1   wr    00020004 00005500 2 00000000 0
dm_rd1     rd    00020004 00000000 f cafe550d 0
dm_full2   wr    00020008 deadbeef f 00000000 0
dm_lane3   wr    00020008 7f000000 8 00000000 0
dm_rd2     rd    00020008 00000000 f 7fadbeef 0
dm_last    wr    00020ffc 0badf00d f 00000000 0
dm_rd_last rd    00020ffc 00000000 f 0badf00d 0
dm_burst   burst 00020100 00000000 f 00000000 0
gp0_out    wr    10000000 000000a5 1 00000000 0
gp0_dir    wr    10000004 0000000f 1 00000000 0
gp1_out    wr    10000010 000001ab 1 00000000 0
gp1_dir    wr    10000014 000000ff 1 00000000 0
gp0_nosel  wr    10000000 00000000 2 00000000 0
gp0_rd_out rd    10000000 00000000 f 000000a5 0
gp0_rd_dir rd    10000004 00000000 f 0000000f 0
gp1_rd_out rd    10000010 00000000 f 0000000b 0
gp1_rd_dir rd    10000014 00000000 f 0000000f 0
gp0_pin_a  pin   10000008 00000000 f 00000000 0
gp1_pin_a  pin   10000018 00000000 f 00000000 0
gp0_pin_b  pin   10000008 00000000 f 00000000 0
gp1_pin_b  pin   10000018 00000000 f 00000000 0
err_far_wr wr    30000000 12345678 f 00000000 1
err_low_wr wr    00000000 12345678 f 00000000 1
err_hole   rd    10000100 00000000 f 00000000 1
err_hole_w wr    10000100 12345678 f 00000000 1
err_offset rd    1000000c 00000000 f 00000000 1
dm_after0  rd    00020000 00000000 f bbcc33aa 0
dm_after1  rd    00020004 00000000 f cafe550d 0
dm_after2  rd    00020008 00000000 f 7fadbeef 0
gp0_after  rd    10000000 00000000 f 000000a5 0

/* project.f */
common/soc_pkg.sv
logic/gpio_port.sv
logic/dmem_ram.sv
bus/shared_bus.sv
bus/bus_decoder.sv
logic/soc_top.sv
tests/soc_asserts.sv
tests/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module soc_tb -o soc_sim &&
./obj_dir/soc_sim | grep -q "Regression passed" &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }
